/* hdl/alu.sv */
`timescale 1ns/100ps

module alu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic [alu_op_w-1:0] i_op,
    input  logic                i_sub,
    input  logic                i_sltu,
    input  logic                i_shift_arith,
    input  logic [1:0]          i_shift_dir,
    input  logic [xlen-1:0]     i_op1,
    input  logic [xlen-1:0]     i_op2,
    output logic [xlen-1:0]     o_result
);

    logic [xlen-1:0] add_b;
    logic [xlen-1:0] add_result;
    logic            carry;

    // subtract as a + ~b + 1
    assign add_b = i_op2 ^ {xlen{i_sub}};

    always_comb begin
        carry = i_sub;
        for (int b = 0; b < xlen; b++) begin
            add_result[b] = i_op1[b] ^ add_b[b] ^ carry;
            carry = (i_op1[b] & add_b[b]) | (i_op1[b] & carry) | (add_b[b] & carry);
        end
    end

    logic lt, ltu, slt_bit;

    comparator u_cmp (
        .i_a   (i_op1),
        .i_b   (i_op2),
        .o_eq  (),
        .o_lt  (lt),
        .o_ltu (ltu)
    );

    // signed or unsigned set-less-than
    assign slt_bit = i_sltu ? ltu : lt;

    logic [xlen-1:0] shift_result;

    shifter u_shifter (
        .i_value  (i_op1),
        .i_shamt  (i_op2[4:0]),
        .i_dir    (i_shift_dir),
        .i_arith  (i_shift_arith),
        .o_result (shift_result)
    );

    assign o_result = ({xlen{i_op[alu_add]}}   & add_result)
                    | ({xlen{i_op[alu_or]}}    & (i_op1 | i_op2))
                    | ({xlen{i_op[alu_and]}}   & (i_op1 & i_op2))
                    | ({xlen{i_op[alu_xor]}}   & (i_op1 ^ i_op2))
                    | ({xlen{i_op[alu_shift]}} & shift_result)
                    | {{(xlen-1){1'b0}}, slt_bit & i_op[alu_slt]};

endmodule

/* hdl/comparator.sv */
`timescale 1ns/100ps

module comparator
    import isa_pkg::*;
(
    input  logic [xlen-1:0] i_a,
    input  logic [xlen-1:0] i_b,
    output logic            o_eq,
    output logic            o_lt,
    output logic            o_ltu
);

    logic below;

    assign o_eq = &(i_a ~^ i_b);

    // a higher differing bit overrides what the lower bits decided
    always_comb begin
        below = 1'b0;
        for (int b = 0; b < xlen; b++) begin
            below = (~i_a[b] & i_b[b]) | ((i_a[b] ~^ i_b[b]) & below);
        end
    end

    assign o_ltu = below;
    // differing signs invert the unsigned answer
    assign o_lt  = (i_a[xlen-1] ^ i_b[xlen-1]) ? i_a[xlen-1] : below;

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    // one-hot alu result select
    localparam int alu_op_w = 6;

    localparam int alu_add   = 0;
    localparam int alu_or    = 1;
    localparam int alu_and   = 2;
    localparam int alu_xor   = 3;
    localparam int alu_slt   = 4;
    localparam int alu_shift = 5;

    // one-hot shifter direction
    localparam int shift_left  = 0;
    localparam int shift_right = 1;

endpackage

/* hdl/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  inst_u               i_inst,
    output logic [4:0]          o_rs1_addr,
    output logic [4:0]          o_rs2_addr,
    output logic [4:0]          o_rd_addr,
    output logic                o_rd_wen,
    output logic                o_op1_pc,
    output logic                o_op2_imm,
    output logic                o_alu_sub,
    output logic                o_alu_sltu,
    output logic                o_shift_arith,
    output logic                o_jump,
    output logic                o_branch,
    output logic                o_br_equal,
    output logic                o_br_unsigned,
    output logic                o_br_invert,
    output logic                o_store,
    output logic [alu_op_w-1:0] o_alu_op,
    output logic [1:0]          o_shift_dir,
    output logic [31:0]         o_imm
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = i_inst.r_fmt.opcode[6:2];
    assign funct3 = i_inst.r_fmt.funct3;
    assign funct7 = i_inst.r_fmt.funct7;

    logic is_load, is_op_imm, is_auipc, is_store, is_op, is_lui;
    logic is_branch, is_jalr, is_jal;

    assign is_load   = opcode == op_load;
    assign is_op_imm = opcode == op_op_imm;
    assign is_auipc  = opcode == op_auipc;
    assign is_store  = opcode == op_store;
    assign is_op     = opcode == op_op;
    assign is_lui    = opcode == op_lui;
    assign is_branch = opcode == op_branch;
    assign is_jalr   = opcode == op_jalr;
    assign is_jal    = opcode == op_jal;

    logic f7_zero, f7_alt, f3_shift;
    assign f7_zero  = funct7 == 7'b0000000;
    assign f7_alt   = funct7 == funct7_alt;
    assign f3_shift = (funct3 == f3_sll) || (funct3 == f3_sr);

    // legal encodings only, anything else falls through as a nop
    logic op_legal, imm_legal, alu_inst, jalr_legal, branch_legal;
    assign op_legal = is_op && (f7_zero || (f7_alt && (funct3 == f3_add || funct3 == f3_sr)));
    assign imm_legal = is_op_imm && (!f3_shift || f7_zero || (f7_alt && funct3 == f3_sr));
    assign alu_inst = op_legal || imm_legal;
    assign jalr_legal = is_jalr && (funct3 == 3'b000);
    // funct3 010 and 011 are not branches
    assign branch_legal = is_branch && (funct3[2:1] != 2'b01);

    assign o_rs1_addr = is_lui ? 5'd0 : i_inst.r_fmt.rs1;
    assign o_rs2_addr = i_inst.r_fmt.rs2;
    assign o_rd_addr  = i_inst.r_fmt.rd;
    assign o_rd_wen   = (alu_inst || is_lui || is_auipc || is_jal || jalr_legal)
                        && (i_inst.r_fmt.rd != 5'd0);

    assign o_op1_pc  = is_branch || is_auipc || is_jal;
    assign o_op2_imm = !is_op;

    assign o_alu_op[alu_add]   = (alu_inst && funct3 == f3_add) || is_lui || is_auipc
                                 || is_store || is_branch || is_jal || is_jalr;
    assign o_alu_op[alu_or]    = alu_inst && funct3 == f3_or;
    assign o_alu_op[alu_and]   = alu_inst && funct3 == f3_and;
    assign o_alu_op[alu_xor]   = alu_inst && funct3 == f3_xor;
    assign o_alu_op[alu_slt]   = alu_inst && (funct3 == f3_slt || funct3 == f3_sltu);
    assign o_alu_op[alu_shift] = alu_inst && f3_shift;

    assign o_alu_sub  = is_op && f7_alt && funct3 == f3_add;
    assign o_alu_sltu = funct3 == f3_sltu;

    assign o_shift_dir[shift_left]  = funct3 == f3_sll;
    assign o_shift_dir[shift_right] = funct3 == f3_sr;
    assign o_shift_arith            = f7_alt;

    assign o_jump        = is_jal || jalr_legal;
    assign o_branch      = branch_legal;
    assign o_br_equal    = !funct3[2];
    assign o_br_unsigned = funct3[1];
    assign o_br_invert   = funct3[0];
    assign o_store       = is_store && funct3 == f3_sw;

    // immediate per format
    logic fmt_i, fmt_s, fmt_b, fmt_u, fmt_j;
    assign fmt_i = is_op_imm || is_jalr || is_load;
    assign fmt_s = is_store;
    assign fmt_b = is_branch;
    assign fmt_u = is_lui || is_auipc;
    assign fmt_j = is_jal;

    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    assign imm_i = {{20{i_inst.i_fmt.imm_11_0[11]}}, i_inst.i_fmt.imm_11_0};
    assign imm_s = {{20{i_inst.s_fmt.imm_11_5[6]}}, i_inst.s_fmt.imm_11_5,
                    i_inst.s_fmt.imm_4_0};
    assign imm_b = {{20{i_inst.b_fmt.imm_12}}, i_inst.b_fmt.imm_11,
                    i_inst.b_fmt.imm_10_5, i_inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {i_inst.u_fmt.imm_31_12, 12'h000};
    assign imm_j = {{12{i_inst.j_fmt.imm_20}}, i_inst.j_fmt.imm_19_12,
                    i_inst.j_fmt.imm_11, i_inst.j_fmt.imm_10_1, 1'b0};

    // r-format has no immediate
    assign o_imm = ({32{fmt_i}} & imm_i) | ({32{fmt_s}} & imm_s) | ({32{fmt_b}} & imm_b)
                 | ({32{fmt_u}} & imm_u) | ({32{fmt_j}} & imm_j);

endmodule

/* hdl/isa_pkg.sv */
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes, instruction bits 6:2
    localparam logic [4:0] op_load   = 5'b00000;
    localparam logic [4:0] op_op_imm = 5'b00100;
    localparam logic [4:0] op_auipc  = 5'b00101;
    localparam logic [4:0] op_store  = 5'b01000;
    localparam logic [4:0] op_op     = 5'b01100;
    localparam logic [4:0] op_lui    = 5'b01101;
    localparam logic [4:0] op_branch = 5'b11000;
    localparam logic [4:0] op_jalr   = 5'b11001;
    localparam logic [4:0] op_jal    = 5'b11011;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_sw   = 3'b010;

    // sub and sra
    localparam logic [6:0] funct7_alt = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, read as each format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

/* hdl/pc_unit.sv */
`timescale 1ns/100ps

module pc_unit
    import isa_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic [xlen-1:0] i_rs1_rdata,
    input  logic [xlen-1:0] i_rs2_rdata,
    input  logic [xlen-1:0] i_alu_result,
    input  logic            i_jump,
    input  logic            i_branch,
    input  logic            i_br_equal,
    input  logic            i_br_unsigned,
    input  logic            i_br_invert,
    output logic [xlen-1:0] o_pc,
    output logic [xlen-1:0] o_rd_wdata
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] next_pc;
    logic            eq, lt, ltu;
    logic            take;

    comparator u_br_cmp (
        .i_a   (i_rs1_rdata),
        .i_b   (i_rs2_rdata),
        .o_eq  (eq),
        .o_lt  (lt),
        .o_ltu (ltu)
    );

    // bne, bge and bgeu are the inverted forms
    assign take = (i_br_equal ? eq : (i_br_unsigned ? ltu : lt)) ^ i_br_invert;

    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = (i_jump || (i_branch && take)) ? {i_alu_result[xlen-1:1], 1'b0}
                                                     : pc_plus4;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // link value for jal and jalr
    assign o_rd_wdata = i_jump ? pc_plus4 : i_alu_result;
    assign o_pc       = pc;

endmodule

/* hdl/reg_lane.sv */
`timescale 1ns/100ps

module reg_lane
    import isa_pkg::*;
(
    input  logic                  i_clk,
    input  logic [reg_addr_w-1:0] i_rs1_addr,
    input  logic [reg_addr_w-1:0] i_rs2_addr,
    input  logic [reg_addr_w-1:0] i_rd_addr,
    input  logic                  i_rd_wen,
    input  logic [7:0]            i_rd_wdata,
    output logic [7:0]            o_rs1_rdata,
    output logic [7:0]            o_rs2_rdata
);

    logic [7:0] mem [2**reg_addr_w];

    always_ff @(posedge i_clk) begin
        if (i_rd_wen) begin
            mem[i_rd_addr] <= i_rd_wdata;
        end
    end

    // x0 is hardwired
    assign o_rs1_rdata = (i_rs1_addr == '0) ? 8'h00 : mem[i_rs1_addr];
    assign o_rs2_rdata = (i_rs2_addr == '0) ? 8'h00 : mem[i_rs2_addr];

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/100ps

module rv_core
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [31:0] i_imem_rdata,
    output logic [31:0] o_imem_addr,
    output logic        o_dmem_wen,
    output logic [31:0] o_dmem_addr,
    output logic [31:0] o_dmem_wdata
);

    // one byte-wide bank per lane
    localparam int lanes = xlen / 8;

    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] rd_addr;
    logic                  rd_wen;
    logic                  op1_pc;
    logic                  op2_imm;
    logic                  alu_sub;
    logic                  alu_sltu;
    logic                  shift_arith;
    logic                  jump;
    logic                  branch;
    logic                  br_equal;
    logic                  br_unsigned;
    logic                  br_invert;
    logic                  store;
    logic [alu_op_w-1:0]   alu_op;
    logic [1:0]            shift_dir;
    logic [xlen-1:0]       imm;

    logic [xlen-1:0] rs1_rdata;
    logic [xlen-1:0] rs2_rdata;
    logic [xlen-1:0] rd_wdata;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;

    inst_decoder u_decoder (
        .i_inst        (i_imem_rdata),
        .o_rs1_addr    (rs1_addr),
        .o_rs2_addr    (rs2_addr),
        .o_rd_addr     (rd_addr),
        .o_rd_wen      (rd_wen),
        .o_op1_pc      (op1_pc),
        .o_op2_imm     (op2_imm),
        .o_alu_sub     (alu_sub),
        .o_alu_sltu    (alu_sltu),
        .o_shift_arith (shift_arith),
        .o_jump        (jump),
        .o_branch      (branch),
        .o_br_equal    (br_equal),
        .o_br_unsigned (br_unsigned),
        .o_br_invert   (br_invert),
        .o_store       (store),
        .o_alu_op      (alu_op),
        .o_shift_dir   (shift_dir),
        .o_imm         (imm)
    );

    for (genvar g = 0; g < lanes; g++) begin : g_lane
        reg_lane u_lane (
            .i_clk       (i_clk),
            .i_rs1_addr  (rs1_addr),
            .i_rs2_addr  (rs2_addr),
            .i_rd_addr   (rd_addr),
            .i_rd_wen    (rd_wen),
            .i_rd_wdata  (rd_wdata[8*g +: 8]),
            .o_rs1_rdata (rs1_rdata[8*g +: 8]),
            .o_rs2_rdata (rs2_rdata[8*g +: 8])
        );
    end

    assign op1 = op1_pc ? pc : rs1_rdata;
    assign op2 = op2_imm ? imm : rs2_rdata;

    alu u_alu (
        .i_op          (alu_op),
        .i_sub         (alu_sub),
        .i_sltu        (alu_sltu),
        .i_shift_arith (shift_arith),
        .i_shift_dir   (shift_dir),
        .i_op1         (op1),
        .i_op2         (op2),
        .o_result      (alu_result)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_rs1_rdata   (rs1_rdata),
        .i_rs2_rdata   (rs2_rdata),
        .i_alu_result  (alu_result),
        .i_jump        (jump),
        .i_branch      (branch),
        .i_br_equal    (br_equal),
        .i_br_unsigned (br_unsigned),
        .i_br_invert   (br_invert),
        .o_pc          (pc),
        .o_rd_wdata    (rd_wdata)
    );

    assign o_imem_addr  = pc;
    assign o_dmem_wen   = store;
    assign o_dmem_addr  = alu_result;
    assign o_dmem_wdata = rs2_rdata;

endmodule

/* hdl/shifter.sv */
`timescale 1ns/100ps

module shifter
    import core_pkg::*;
(
    input  logic [31:0] i_value,
    input  logic [4:0]  i_shamt,
    input  logic [1:0]  i_dir,
    input  logic        i_arith,
    output logic [31:0] o_result
);

    logic [31:0] sl16, sl8, sl4, sl2, sl1;
    logic [31:0] sr16, sr8, sr4, sr2, sr1;
    logic        fill;

    assign sl16 = i_shamt[4] ? {i_value[15:0], 16'h0000} : i_value;
    assign sl8  = i_shamt[3] ? {sl16[23:0], 8'h00} : sl16;
    assign sl4  = i_shamt[2] ? {sl8[27:0], 4'h0} : sl8;
    assign sl2  = i_shamt[1] ? {sl4[29:0], 2'b00} : sl4;
    assign sl1  = i_shamt[0] ? {sl2[30:0], 1'b0} : sl2;

    // sign fill for sra
    assign fill = i_arith & i_value[31];

    assign sr16 = i_shamt[4] ? {{16{fill}}, i_value[31:16]} : i_value;
    assign sr8  = i_shamt[3] ? {{8{fill}}, sr16[31:8]} : sr16;
    assign sr4  = i_shamt[2] ? {{4{fill}}, sr8[31:4]} : sr8;
    assign sr2  = i_shamt[1] ? {{2{fill}}, sr4[31:2]} : sr4;
    assign sr1  = i_shamt[0] ? {fill, sr2[31:1]} : sr2;

    assign o_result = ({32{i_dir[shift_left]}} & sl1) | ({32{i_dir[shift_right]}} & sr1);

endmodule

/* project.f */
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/comparator.sv
hdl/shifter.sv
hdl/alu.sv
hdl/reg_lane.sv
hdl/inst_decoder.sv
hdl/pc_unit.sv
hdl/rv_core.sv
verif/tb_iss_pkg.sv
verif/tb_rv_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_rv_core -o sim_rv_core

out=$(./obj_dir/sim_rv_core) || true
echo "$out"

if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1

/* verif/tb_iss_pkg.sv */
package tb_iss_pkg;

    import isa_pkg::*;

    logic [31:0] lfsr_state = 32'ha26;
    logic [31:0] model_regs [32] = '{default: 32'h0};
    logic [31:0] model_pc = 32'h0;

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // upper part rounded so that a following addi lands on value
    function automatic logic [31:0] make_lui(input logic [4:0] rd, input logic [31:0] value);
        inst_u w;
        w.u_fmt.imm_31_12 = value[31:12] + {19'd0, value[11]};
        w.u_fmt.rd = rd;
        w.u_fmt.opcode = {op_lui, 2'b11};
        return w;
    endfunction

    function automatic logic [31:0] make_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        inst_u w;
        w.i_fmt.imm_11_0 = imm;
        w.i_fmt.rs1 = rs1;
        w.i_fmt.funct3 = f3_add;
        w.i_fmt.rd = rd;
        w.i_fmt.opcode = {op_op_imm, 2'b11};
        return w;
    endfunction

    function automatic logic [31:0] store_of(input logic [4:0] src);
        inst_u w;
        w = rand_bits(32);
        w.s_fmt.opcode = {op_store, 2'b11};
        w.s_fmt.funct3 = f3_sw;
        w.s_fmt.rs2 = src;
        return w;
    endfunction

    // random fields first, then the opcode and funct bits are made legal
    function automatic logic [31:0] random_inst();
        inst_u      w;
        logic [3:0] kind;
        logic [2:0] f3;
        logic       alt;
        w = rand_bits(32);
        kind = 4'(rand_bits(4));
        alt = 1'(rand_bits(1));
        f3 = w.r_fmt.funct3;
        if (kind < 4'd5) begin
            w.r_fmt.opcode = {op_op, 2'b11};
            w.r_fmt.funct7 = (alt && (f3 == f3_add || f3 == f3_sr)) ? funct7_alt : 7'h00;
        end else if (kind < 4'd9) begin
            w.i_fmt.opcode = {op_op_imm, 2'b11};
            if (f3 == f3_sll || f3 == f3_sr) begin
                w.r_fmt.funct7 = (alt && f3 == f3_sr) ? funct7_alt : 7'h00;
            end
        end else if (kind < 4'd11) begin
            w.b_fmt.opcode = {op_branch, 2'b11};
            // 010 and 011 are no branch condition
            if (f3[2:1] == 2'b01) begin
                w.b_fmt.funct3[2] = 1'b1;
            end
        end else if (kind == 4'd11) begin
            w.j_fmt.opcode = {op_jal, 2'b11};
        end else if (kind == 4'd12) begin
            w.i_fmt.opcode = {op_jalr, 2'b11};
            w.i_fmt.funct3 = 3'b000;
        end else if (kind == 4'd13) begin
            w.u_fmt.opcode = {op_lui, 2'b11};
        end else if (kind == 4'd14) begin
            w.u_fmt.opcode = {op_auipc, 2'b11};
        end else begin
            // misc-mem, executes as a nop
            w.r_fmt.opcode = 7'b0001111;
        end
        return w;
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        r;
        sa = a;
        sb = b;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'd0, sa < sb};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = sa >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // one instruction on the model state, returns the expected store
    function automatic void execute(input logic [31:0] word, output logic st_en,
                                    output logic [31:0] st_addr, output logic [31:0] st_data);
        logic [31:0]        a, b, res, next;
        logic [31:0]        imm_i, imm_s, imm_b, imm_j, imm_u;
        logic signed [31:0] sa, sb;
        logic [2:0]         f3;
        logic               wr, take;
        a = model_regs[word[19:15]];
        b = model_regs[word[24:20]];
        sa = a;
        sb = b;
        f3 = word[14:12];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
        imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        imm_u = {word[31:12], 12'h000};
        res = 32'h0;
        wr = 1'b0;
        take = 1'b0;
        next = model_pc + 32'd4;
        st_en = 1'b0;
        st_addr = 32'h0;
        st_data = 32'h0;
        case (word[6:2])
            op_op: begin
                res = alu_model(f3, word[30], a, b);
                wr = 1'b1;
            end
            op_op_imm: begin
                res = alu_model(f3, f3 == f3_sr && word[30], a, imm_i);
                wr = 1'b1;
            end
            op_lui: begin
                res = imm_u;
                wr = 1'b1;
            end
            op_auipc: begin
                res = model_pc + imm_u;
                wr = 1'b1;
            end
            op_jal: begin
                res = model_pc + 32'd4;
                wr = 1'b1;
                next = (model_pc + imm_j) & ~32'd1;
            end
            op_jalr: begin
                res = model_pc + 32'd4;
                wr = 1'b1;
                next = (a + imm_i) & ~32'd1;
            end
            op_branch: begin
                case (f3)
                    3'd0: take = a == b;
                    3'd1: take = a != b;
                    3'd4: take = sa < sb;
                    3'd5: take = sa >= sb;
                    3'd6: take = a < b;
                    default: take = a >= b;
                endcase
                if (take) begin
                    next = (model_pc + imm_b) & ~32'd1;
                end
            end
            op_store: begin
                st_en = f3 == f3_sw;
                st_addr = a + imm_s;
                st_data = b;
            end
            default: begin
            end
        endcase
        if (wr && word[11:7] != 5'd0) begin
            model_regs[word[11:7]] = res;
        end
        model_pc = next;
    endfunction

endpackage

/* verif/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core
    import tb_iss_pkg::*;
();

    localparam logic [31:0] RESET_PC   = 32'h0000_0100;
    localparam int          period     = 20;
    localparam int          groups     = 1000;
    localparam int          max_cycles = 5000;
    // addi x0, x0, 0
    localparam logic [31:0] nop        = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_rdata;
    logic [31:0] imem_addr;
    logic        dmem_wen;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_imem_rdata (imem_rdata),
        .o_imem_addr  (imem_addr),
        .o_dmem_wen   (dmem_wen),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata)
    );

    always #(period / 2) clk = ~clk;

    task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // called at a falling edge, returns at the next one
    task automatic issue(input logic [31:0] word);
        logic        st_en;
        logic [31:0] st_addr;
        logic [31:0] st_data;
        imem_rdata = word;
        expect_equal(imem_addr, model_pc, "instruction address");
        #(period / 4);
        execute(word, st_en, st_addr, st_data);
        expect_equal({31'd0, dmem_wen}, {31'd0, st_en}, "store strobe");
        if (st_en) begin
            expect_equal(dmem_addr, st_addr, "store address");
            expect_equal(dmem_wdata, st_data, "store data");
        end
        @(negedge clk);
    endtask

    initial begin
        for (int c = 0; c < max_cycles; c++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] value;
        logic [31:0] word;
        clk = 1'b0;
        rst_n = 1'b0;
        imem_rdata = nop;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            expect_equal(imem_addr, RESET_PC, "address in reset");
            expect_equal({31'd0, dmem_wen}, 32'd0, "store strobe in reset");
        end
        rst_n = 1'b1;
        model_pc = RESET_PC;
        issue(nop);

        // known value in every register
        for (int r = 1; r < 32; r++) begin
            value = rand_bits(32);
            issue(make_lui(5'(r), value));
            issue(make_addi(5'(r), 5'(r), value[11:0]));
        end

        // each random instruction is followed by a store of its rd
        for (int n = 0; n < groups; n++) begin
            word = random_inst();
            issue(word);
            issue(store_of(word[11:7]));
        end

        $display("Verification passed");
        $finish;
    end

endmodule
